// File: hw/main_bus_cfg.svh
`ifndef MAIN_BUS_CFG_SVH
`define MAIN_BUS_CFG_SVH

// number of 64K program ROM pages mapped from address 0
`define ROM_PAGES 6

// rotary counters step once every 2**ROT_DIV_W frames
`define ROT_DIV_W 3

// cycles from blanking start to the display acknowledge
`define DISP_ACK_DLY 2

`endif

// File: hw/main_bus_pkg.sv
`default_nettype none

package main_bus_pkg;

    // CPU side of the bus, strobes active low
    typedef struct packed {
        logic [23:1] addr;
        logic [15:0] dout;      // write data from the CPU
        logic        rnw;
        logic        uds_n;
        logic        lds_n;
        logic        as_n;
    } cpu_bus_t;

    // display view, 0x24'xxxx
    typedef struct packed {
        logic [1:0] hi;
        logic [1:0] region;     // A[21:20]
        logic [1:0] sub;        // A[19:18]
        logic [1:0] gap;
        logic [2:0] chip;       // A[15:13], tilemap chip register block
        logic [1:0] reg_sel;    // A[12:11], only for the third chip
        logic [9:0] lo;
    } disp_addr_t;

    // I/O view, 0x3x'xxxx
    typedef struct packed {
        logic [1:0] hi;
        logic [1:0] region;     // A[21:20]
        logic [2:0] page;
        logic [2:0] block;      // A[16:14]
        logic [8:0] gap;
        logic       ul;         // A[4], set for the write ports
        logic [2:0] port;       // A[3:1]
    } io_addr_t;

    typedef union packed {
        disp_addr_t disp;
        io_addr_t   io;
    } cpu_addr_u;

    typedef struct packed {
        logic       rom;
        logic       ram;        // work RAM plus tilemap scroll and map
        logic [1:0] pal;
        logic       obj;
        logic       fmode;
        logic       fscr;
        logic       fmap;
        logic       bmode;
        logic       bscr;
        logic       bmap;
        logic       cmode;
        logic       cscr;
        logic       cmap;
    } chip_sel_t;

    typedef struct packed {
        logic [2:0] cab_rd;
        logic       mcu_rd;
        logic [1:0] rot_rd;
        logic       prisel;
        logic       obj_copy;
        logic       snd;
        logic       mcu_wr;
        logic       vint_clr;
        logic       mixpsel;
    } port_sel_t;

    typedef struct packed {
        logic [8:0] joy1;       // active low
        logic [8:0] joy2;
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic [7:0] dipsw_a;
        logic [7:0] dipsw_b;
    } cab_in_t;

    typedef struct packed {
        logic [7:0]  snd_latch;
        logic [15:0] mcu_din;
        logic [2:0]  prisel;
        logic        mixpsel;
    } latch_t;

endpackage

`default_nettype wire

// File: hw/addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_bus_cfg.svh"

module addr_decoder import main_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  cpu_bus_t  bus,
    output chip_sel_t sel_q,
    output port_sel_t port_q,
    output logic      disp_q
);

    cpu_addr_u a;
    chip_sel_t sel_d;
    port_sel_t port_d;
    logic      wram_d;
    logic      disp_d;

    assign a = bus.addr;

    always_comb begin
        sel_d  = '0;
        port_d = '0;
        wram_d = 1'b0;
        if (!bus.as_n) begin
            case (a.io.region)
                2'd0: sel_d.rom = (bus.addr[19:16] < 4'(`ROM_PAGES)) && bus.rnw;
                2'd2: begin
                    if (a.disp.sub == 2'd1) begin
                        case (a.disp.chip)
                            3'd0: sel_d.fmode = 1'b1;
                            3'd1: sel_d.fscr  = 1'b1;
                            3'd2: sel_d.fmap  = 1'b1;
                            3'd3: sel_d.bmode = 1'b1;
                            3'd4: sel_d.bscr  = 1'b1;
                            3'd5: sel_d.bmap  = 1'b1;
                            3'd6: begin     // third chip, on the second board
                                case (a.disp.reg_sel)
                                    2'd0: sel_d.cmode = 1'b1;
                                    2'd1: sel_d.cscr  = 1'b1;
                                    2'd2: sel_d.cmap  = 1'b1;
                                    default: ;
                                endcase
                            end
                            default: ;
                        endcase
                    end
                end
                2'd3: begin
                    case (a.io.block)
                        3'd0: begin     // rotary knobs
                            if (bus.rnw && a.io.port == 3'd0)
                                port_d.rot_rd[0] = 1'b1;
                            if (bus.rnw && a.io.port == 3'd1)
                                port_d.rot_rd[1] = 1'b1;
                        end
                        3'd3: begin
                            if (bus.rnw && !a.io.ul) begin
                                case (a.io.port)
                                    3'd0, 3'd1, 3'd2: port_d.cab_rd[a.io.port[1:0]] = 1'b1;
                                    3'd4: port_d.mcu_rd = 1'b1;
                                    default: ;
                                endcase
                            end
                            if (!bus.rnw && a.io.ul) begin
                                case (a.io.port)
                                    3'd0: port_d.prisel   = 1'b1;
                                    3'd1: port_d.obj_copy = 1'b1;
                                    3'd2: port_d.snd      = 1'b1;
                                    3'd3: port_d.mcu_wr   = 1'b1;
                                    3'd4: port_d.vint_clr = 1'b1;
                                    3'd5: port_d.mixpsel  = 1'b1;
                                    default: ;
                                endcase
                            end
                        end
                        3'd4: sel_d.pal[0] = 1'b1;  // palette low half
                        3'd5: sel_d.pal[1] = 1'b1;
                        3'd6: wram_d       = 1'b1;
                        3'd7: sel_d.obj    = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
        // scroll and map memories sit in the same RAM as the work area
        sel_d.ram = wram_d | sel_d.fscr | sel_d.fmap | sel_d.bscr | sel_d.bmap
                  | sel_d.cscr | sel_d.cmap;
    end

    assign disp_d = |{sel_d.fmode, sel_d.fscr, sel_d.fmap, sel_d.bmode, sel_d.bscr,
                      sel_d.bmap, sel_d.cmode, sel_d.cscr, sel_d.cmap};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_q  <= '0;
            port_q <= '0;
            disp_q <= 1'b0;
        end else begin
            sel_q  <= sel_d;
            port_q <= port_d;
            disp_q <= disp_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/io_registers.sv
`timescale 1ns/1ps
`default_nettype none

module io_registers import main_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cpu_bus_t   bus,
    input  port_sel_t  port_q,
    input  logic       lvbl,
    input  logic       sec2,
    input  logic       ext_irq_n,
    output latch_t     latch,
    output logic       snd_req,
    output logic       obj_copy,
    output logic [2:0] ipl_n
);

    logic [4:0] wr_now;
    logic [4:0] wr_l;
    logic [4:0] wr_rise;
    logic       lvbl_l;
    logic       sec2_l;
    logic       vint;
    logic       secirq;   // MCU wants attention

    assign wr_now  = {port_q.mixpsel, port_q.mcu_wr, port_q.snd, port_q.obj_copy,
                      port_q.prisel};
    assign wr_rise = wr_now & ~wr_l;   // first cycle of each write access

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_l     <= '0;
            latch    <= '0;
            snd_req  <= 1'b0;
            obj_copy <= 1'b0;
            lvbl_l   <= 1'b0;
            sec2_l   <= 1'b0;
            vint     <= 1'b0;
            secirq   <= 1'b0;
        end else begin
            wr_l     <= wr_now;
            snd_req  <= wr_rise[2];
            obj_copy <= wr_rise[1];    // object DMA kick
            if (wr_rise[0] && !bus.lds_n)
                latch.prisel <= bus.dout[2:0];
            if (wr_rise[2] && !bus.lds_n)
                latch.snd_latch <= bus.dout[7:0];
            if (wr_rise[3]) begin
                if (!bus.uds_n) latch.mcu_din[15:8] <= bus.dout[15:8];
                if (!bus.lds_n) latch.mcu_din[7:0]  <= bus.dout[7:0];
            end
            if (wr_rise[4] && !bus.lds_n)
                latch.mixpsel <= bus.dout[0];

            lvbl_l <= lvbl;
            if (port_q.vint_clr)
                vint <= 1'b0;
            else if (lvbl_l && !lvbl)
                vint <= 1'b1;    // start of vertical blank

            sec2_l <= sec2;
            if (port_q.mcu_rd)
                secirq <= 1'b0;  // reading the mailbox acknowledges
            else if (!sec2_l && sec2)
                secirq <= 1'b1;
        end
    end

    always_comb begin
        if (vint)            ipl_n = ~3'd6;
        else if (secirq)     ipl_n = ~3'd5;
        else if (!ext_irq_n) ipl_n = ~3'd4;
        else                 ipl_n = ~3'd0;
    end

endmodule

`default_nettype wire

// File: hw/cab_inputs.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_bus_cfg.svh"

module cab_inputs import main_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cab_in_t     cab,
    input  logic        lvbl,
    input  port_sel_t   port_q,
    output logic [15:0] cab_word,
    output logic [11:0] rot1,
    output logic [11:0] rot2
);

    logic [8:0]            sort1;
    logic [8:0]            sort2;
    logic                  lvbl_l;
    logic [`ROT_DIV_W-1:0] frame_cnt;

    // board wiring has the four directions in reverse order
    function automatic logic [8:0] sort_joy(input logic [8:0] joy);
        return {joy[8:4], joy[0], joy[1], joy[2], joy[3]};
    endfunction

    // buttons 6 and 7 turn the knob, both active low
    function automatic logic [11:0] rot_step(input logic [11:0] rot, input logic [8:0] joy);
        logic [11:0] nxt;
        nxt = rot;
        if (!joy[6]) nxt = (rot == '0) ? 12'h001 : {rot[10:0], rot[11]};
        if (!joy[7]) nxt = (rot == '0) ? 12'h800 : {rot[0], rot[11:1]};
        return nxt;
    endfunction

    assign sort1 = sort_joy(cab.joy1);
    assign sort2 = sort_joy(cab.joy2);

    always_comb begin
        cab_word = 16'hffff;
        if (port_q.cab_rd[0])
            cab_word = {sort2[7:0], sort1[7:0]};
        else if (port_q.cab_rd[1])
            cab_word = {8'hff, ~lvbl, cab.service, cab.coin, cab.start, sort2[8], sort1[8]};
        else if (port_q.cab_rd[2])
            cab_word = {cab.dipsw_b, cab.dipsw_a};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l    <= 1'b0;
            frame_cnt <= '0;
            rot1      <= '0;
            rot2      <= '0;
        end else begin
            lvbl_l <= lvbl;
            if (lvbl_l && !lvbl) begin  // one per frame
                frame_cnt <= frame_cnt + 1'b1;
                if (frame_cnt == '0) begin
                    rot1 <= rot_step(rot1, cab.joy1);
                    rot2 <= rot_step(rot2, cab.joy2);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module read_mux import main_bus_pkg::*; (
    input  logic        clk,
    input  chip_sel_t   sel_q,
    input  port_sel_t   port_q,
    input  logic [15:0] cab_word,
    input  logic [11:0] rot1,
    input  logic [11:0] rot2,
    input  logic [15:0] rom_data,
    input  logic [15:0] ram_data,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,
    input  logic [15:0] ba0_dout,
    input  logic [15:0] ba1_dout,
    input  logic [15:0] ba2_dout,
    input  logic [15:0] mcu_dout,
    output logic [15:0] rd_data
);

    // open bus reads back as all ones
    always_ff @(posedge clk) begin
        if (sel_q.ram)              rd_data <= ram_data;
        else if (sel_q.rom)         rd_data <= rom_data;
        else if (|sel_q.pal)        rd_data <= pal_dout;
        else if (sel_q.obj)         rd_data <= obj_dout;
        else if (|port_q.cab_rd)    rd_data <= cab_word;
        else if (sel_q.fmode)       rd_data <= ba0_dout;
        else if (sel_q.bmode)       rd_data <= ba1_dout;
        else if (sel_q.cmode)       rd_data <= ba2_dout;
        else if (port_q.mcu_rd)     rd_data <= mcu_dout;
        else if (port_q.rot_rd[0])  rd_data <= {4'hf, ~rot1};
        else if (port_q.rot_rd[1])  rd_data <= {4'hf, ~rot2};
        else                        rd_data <= 16'hffff;
    end

endmodule

`default_nettype wire

// File: hw/wait_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_bus_cfg.svh"

module wait_gen import main_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  cpu_bus_t  bus,
    input  chip_sel_t sel_q,
    input  logic      disp_q,
    input  logic      lvbl,
    input  logic      lhbl,
    input  logic      rom_ok,
    input  logic      ram_ok,
    output logic      dtack_n
);

    localparam int CNT_W = $clog2(`DISP_ACK_DLY + 2);
    localparam logic [CNT_W-1:0] DISP_DONE = CNT_W'(`DISP_ACK_DLY);

    logic             as_l;       // selects are valid from now on
    logic             ok_dly;
    logic [CNT_W-1:0] disp_cnt;
    logic             blank;
    logic             disp_busy;
    logic             bus_busy;

    assign blank     = ~lvbl | ~lhbl;
    assign disp_busy = disp_cnt != DISP_DONE;
    assign bus_busy  = (sel_q.rom & ~ok_dly)
                     | (sel_q.ram & ~ram_ok)
                     | (disp_q & disp_busy);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            as_l     <= 1'b0;
            ok_dly   <= 1'b0;
            disp_cnt <= '0;
            dtack_n  <= 1'b1;
        end else begin
            as_l   <= ~bus.as_n;
            ok_dly <= rom_ok;   // ROM data settles one cycle after ok

            // tilemap chips only take CPU accesses during blanking
            // once blanking is seen the count runs to the end
            if (!disp_q)
                disp_cnt <= '0;
            else if ((blank || disp_cnt != '0) && disp_busy)
                disp_cnt <= disp_cnt + 1'b1;

            if (bus.as_n)
                dtack_n <= 1'b1;
            else if (as_l && !bus_busy)
                dtack_n <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/main_bus.sv
`timescale 1ns/1ps
`default_nettype none

module main_bus import main_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cpu_bus_t    bus,
    input  cab_in_t     cab,
    input  logic        lvbl,
    input  logic        lhbl,
    input  logic        ext_irq_n,
    input  logic        sec2,        // MCU interrupt request
    input  logic        rom_ok,
    input  logic        ram_ok,
    input  logic [15:0] rom_data,
    input  logic [15:0] ram_data,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,
    input  logic [15:0] ba0_dout,
    input  logic [15:0] ba1_dout,
    input  logic [15:0] ba2_dout,
    input  logic [15:0] mcu_dout,
    output chip_sel_t   sel,
    output latch_t      latch,
    output logic        snd_req,
    output logic        obj_copy,
    output logic [15:0] rd_data,
    output logic        dtack_n,
    output logic [2:0]  ipl_n
);

    port_sel_t   port_q;
    logic        disp_q;
    logic [15:0] cab_word;
    logic [11:0] rot1;
    logic [11:0] rot2;

    addr_decoder u_decode (
        .clk    (clk),
        .rst    (rst),
        .bus    (bus),
        .sel_q  (sel),
        .port_q (port_q),
        .disp_q (disp_q)
    );

    io_registers u_io (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .port_q    (port_q),
        .lvbl      (lvbl),
        .sec2      (sec2),
        .ext_irq_n (ext_irq_n),
        .latch     (latch),
        .snd_req   (snd_req),
        .obj_copy  (obj_copy),
        .ipl_n     (ipl_n)
    );

    cab_inputs u_cab (
        .clk      (clk),
        .rst      (rst),
        .cab      (cab),
        .lvbl     (lvbl),
        .port_q   (port_q),
        .cab_word (cab_word),
        .rot1     (rot1),
        .rot2     (rot2)
    );

    read_mux u_rdmux (
        .clk      (clk),
        .sel_q    (sel),
        .port_q   (port_q),
        .cab_word (cab_word),
        .rot1     (rot1),
        .rot2     (rot2),
        .rom_data (rom_data),
        .ram_data (ram_data),
        .pal_dout (pal_dout),
        .obj_dout (obj_dout),
        .ba0_dout (ba0_dout),
        .ba1_dout (ba1_dout),
        .ba2_dout (ba2_dout),
        .mcu_dout (mcu_dout),
        .rd_data  (rd_data)
    );

    wait_gen u_wait (
        .clk     (clk),
        .rst     (rst),
        .bus     (bus),
        .sel_q   (sel),
        .disp_q  (disp_q),
        .lvbl    (lvbl),
        .lhbl    (lhbl),
        .rom_ok  (rom_ok),
        .ram_ok  (ram_ok),
        .dtack_n (dtack_n)
    );

endmodule

`default_nettype wire

// File: sim/bus_model.svh
`ifndef BUS_MODEL_SVH
`define BUS_MODEL_SVH

// expected selects for one address and direction
function automatic void decode_model(input logic [23:1] a, input logic rnw,
                                     output chip_sel_t s, output port_sel_t p);
    logic wram;
    s = '0;
    p = '0;
    wram = 1'b0;
    case (a[21:20])
        2'd0: s.rom = rnw && (int'(a[19:16]) < `ROM_PAGES);
        2'd2: begin
            if (a[19:18] == 2'd1) begin
                case (a[15:13])
                    3'd0: s.fmode = 1'b1;
                    3'd1: s.fscr = 1'b1;
                    3'd2: s.fmap = 1'b1;
                    3'd3: s.bmode = 1'b1;
                    3'd4: s.bscr = 1'b1;
                    3'd5: s.bmap = 1'b1;
                    3'd6: begin
                        if (a[12:11] == 2'd0) s.cmode = 1'b1;
                        if (a[12:11] == 2'd1) s.cscr = 1'b1;
                        if (a[12:11] == 2'd2) s.cmap = 1'b1;
                    end
                    default: ;
                endcase
            end
        end
        2'd3: begin
            case (a[16:14])
                3'd0: begin
                    if (rnw && a[3:1] == 3'd0) p.rot_rd[0] = 1'b1;
                    if (rnw && a[3:1] == 3'd1) p.rot_rd[1] = 1'b1;
                end
                3'd3: begin
                    if (rnw && !a[4] && a[3:1] <= 3'd2) p.cab_rd[a[2:1]] = 1'b1;
                    if (rnw && !a[4] && a[3:1] == 3'd4) p.mcu_rd = 1'b1;
                    if (!rnw && a[4]) begin
                        p.prisel   = (a[3:1] == 3'd0);
                        p.obj_copy = (a[3:1] == 3'd1);
                        p.snd      = (a[3:1] == 3'd2);
                        p.mcu_wr   = (a[3:1] == 3'd3);
                        p.vint_clr = (a[3:1] == 3'd4);
                        p.mixpsel  = (a[3:1] == 3'd5);
                    end
                end
                3'd4: s.pal[0] = 1'b1;
                3'd5: s.pal[1] = 1'b1;
                3'd6: wram = 1'b1;
                3'd7: s.obj = 1'b1;
                default: ;
            endcase
        end
        default: ;
    endcase
    s.ram = wram | s.fscr | s.fmap | s.bscr | s.bmap | s.cscr | s.cmap;
endfunction

function automatic logic disp_model(input chip_sel_t s);
    return s.fmode | s.fscr | s.fmap | s.bmode | s.bscr | s.bmap | s.cmode | s.cscr | s.cmap;
endfunction

// direction bits come in reversed on the harness
function automatic logic [8:0] joy_sorted(input logic [8:0] j);
    return {j[8:4], j[0], j[1], j[2], j[3]};
endfunction

function automatic logic [15:0] cab_word_model(input cab_in_t c, input logic vb, input int idx);
    logic [8:0] s1;
    logic [8:0] s2;
    s1 = joy_sorted(c.joy1);
    s2 = joy_sorted(c.joy2);
    if (idx == 0) return {s2[7:0], s1[7:0]};
    if (idx == 1) return {8'hff, ~vb, c.service, c.coin, c.start, s2[8], s1[8]};
    return {c.dipsw_b, c.dipsw_a};
endfunction

// right button wins when both are held
function automatic logic [11:0] rot_next(input logic [11:0] r, input logic [8:0] j);
    if (!j[7]) return (r == 12'd0) ? 12'h800 : {r[0], r[11:1]};
    if (!j[6]) return (r == 12'd0) ? 12'h001 : {r[10:0], r[11]};
    return r;
endfunction

function automatic logic [2:0] ipl_model(input logic vi, input logic si, input logic ext_n);
    if (vi) return 3'd6;
    if (si) return 3'd5;
    if (!ext_n) return 3'd4;
    return 3'd0;
endfunction

`endif

// File: sim/main_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "main_bus_cfg.svh"

module main_bus_tb import main_bus_pkg::*; ();

    localparam int N_ACC      = 400;
    localparam int WORST_WAIT = 28;     // worst cycles per access including pulses
    localparam int CYC_LIMIT  = 10 + N_ACC * WORST_WAIT;

    logic        clk = 1'b0;
    logic        rst;
    cpu_bus_t    bus;
    cab_in_t     cab;
    logic        lvbl;
    logic        lhbl;
    logic        ext_irq_n;
    logic        sec2;
    logic        rom_ok;
    logic        ram_ok;
    logic [15:0] rom_data;
    logic [15:0] ram_data;
    logic [15:0] pal_dout;
    logic [15:0] obj_dout;
    logic [15:0] ba0_dout;
    logic [15:0] ba1_dout;
    logic [15:0] ba2_dout;
    logic [15:0] mcu_dout;
    chip_sel_t   sel;
    latch_t      latch;
    logic        snd_req;
    logic        obj_copy;
    logic [15:0] rd_data;
    logic        dtack_n;
    logic [2:0]  ipl_n;

    logic [31:0] rnd_state = 32'h27ec_9612;
    int          err_val = 0;
    int          err_other = 0;
    int          cycles = 0;
    int          snd_seen = 0;
    int          obj_seen = 0;
    int          snd_exp = 0;
    int          obj_exp = 0;

    // reference state
    latch_t      latch_m = '0;
    logic        vint_m = 1'b0;
    logic        secirq_m = 1'b0;
    logic [11:0] rot1_m = '0;
    logic [11:0] rot2_m = '0;
    logic [2:0]  frame_m = '0;

    `include "bus_model.svh"

    function automatic logic [15:0] read_model(input chip_sel_t s, input port_sel_t p);
        if (s.ram) return ram_data;
        if (s.rom) return rom_data;
        if (|s.pal) return pal_dout;
        if (s.obj) return obj_dout;
        if (p.cab_rd[0]) return cab_word_model(cab, lvbl, 0);
        if (p.cab_rd[1]) return cab_word_model(cab, lvbl, 1);
        if (p.cab_rd[2]) return cab_word_model(cab, lvbl, 2);
        if (s.fmode) return ba0_dout;
        if (s.bmode) return ba1_dout;
        if (s.cmode) return ba2_dout;
        if (p.mcu_rd) return mcu_dout;
        if (p.rot_rd[0]) return {4'hf, ~rot1_m};
        if (p.rot_rd[1]) return {4'hf, ~rot2_m};
        return 16'hffff;   // open bus
    endfunction

    main_bus dut_i (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .cab       (cab),
        .lvbl      (lvbl),
        .lhbl      (lhbl),
        .ext_irq_n (ext_irq_n),
        .sec2      (sec2),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .ba0_dout  (ba0_dout),
        .ba1_dout  (ba1_dout),
        .ba2_dout  (ba2_dout),
        .mcu_dout  (mcu_dout),
        .sel       (sel),
        .latch     (latch),
        .snd_req   (snd_req),
        .obj_copy  (obj_copy),
        .rd_data   (rd_data),
        .dtack_n   (dtack_n),
        .ipl_n     (ipl_n)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYC_LIMIT) begin
            $display("timeout: no end of test after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!rst && snd_req) snd_seen <= snd_seen + 1;
        if (!rst && obj_copy) obj_seen <= obj_seen + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] rand_next();
        rnd_state = xorshift(rnd_state);
        return rnd_state;
    endfunction

    task automatic check_sel(input chip_sel_t exp, input chip_sel_t act);
        if (act !== exp) begin
            $display("** Error at %0t: sel expected %h got %h", $time, exp, act);
            err_val++;
        end
    endtask

    task automatic check_latch(input latch_t exp, input latch_t act);
        if (act !== exp) begin
            $display("** Error at %0t: latch expected %h got %h", $time, exp, act);
            err_val++;
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
            err_val++;
        end
    endtask

    task automatic check_ipl(input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp) begin
            $display("** Error at %0t: ipl_n expected %b got %b", $time, exp, act);
            err_val++;
        end
    endtask

    // one frame where falling lvbl sets vint and may step the knobs
    task automatic frame_pulse();
        @(posedge clk);
        lvbl <= 1'b0;
        vint_m = 1'b1;
        if (frame_m == 3'd0) begin
            rot1_m = rot_next(rot1_m, cab.joy1);
            rot2_m = rot_next(rot2_m, cab.joy2);
        end
        frame_m = frame_m + 3'd1;
        repeat (2) @(posedge clk);
        lvbl <= 1'b1;
        @(posedge clk);
    endtask

    task automatic sec2_pulse();
        @(posedge clk);
        sec2 <= 1'b1;
        secirq_m = 1'b1;
        repeat (2) @(posedge clk);
        sec2 <= 1'b0;
        @(posedge clk);
    endtask

    task automatic make_addr(output logic [23:1] a, output logic rnw,
                             output logic [1:0] ds_n, output logic [15:0] wdata);
        logic [31:0] r;
        logic [31:0] t;
        r = rand_next();
        t = rand_next();
        a = t[23:1];
        wdata = t[31:16];
        rnw = r[6];
        case (r[2:0])
            3'd0: begin     // ROM pages including some past the limit
                a[21:20] = 2'd0;
                a[19:16] = {1'b0, r[5:3]};
                rnw = r[6] | r[7];
            end
            3'd1: begin
                a[21:20] = 2'd2;
                a[19:18] = r[8] ? 2'd1 : r[4:3];
                a[15:13] = r[11:9];
                a[12:11] = r[13:12];
            end
            3'd3: begin
                a[21:20] = 2'd3;
                a[16:14] = 3'd0;
                a[3:1]   = {1'b0, r[4:3]};
                rnw = r[6] | r[7];
            end
            3'd4: begin
                a[21:20] = 2'd3;
                a[16:14] = {1'b1, r[4:3]};
            end
            3'd5: ;         // anywhere
            default: begin  // port block mostly with the matching direction
                a[21:20] = 2'd3;
                a[16:14] = 3'd3;
                a[4]     = r[3];
                a[3:1]   = r[11:9];
                rnw = (r[14:12] == 3'd0) ? r[3] : !r[3];
            end
        endcase
        ds_n = (r[16:15] == 2'd0) ? r[18:17] : 2'b00;
    endtask

    task automatic do_access(input logic [23:1] a, input logic rnw,
                             input logic [1:0] ds_n, input logic [15:0] wdata);
        chip_sel_t   sel_m;
        port_sel_t   port_m;
        logic [15:0] rd_m;
        logic [31:0] r;
        int          d_rom;
        int          d_ram;
        int          d_blk;
        int          k;
        int          exp_k;
        decode_model(a, rnw, sel_m, port_m);
        r = rand_next();
        d_rom = int'(r[3:0]) % 6;
        d_ram = int'(r[7:4]) % 6;
        d_blk = int'(r[11:8]) % 6;
        exp_k = 2;
        if (sel_m.rom) exp_k = 2 + d_rom;     // rom_ok seen for one cycle
        if (sel_m.ram && d_ram + 1 > exp_k) exp_k = d_ram + 1;
        if (disp_model(sel_m)) begin
            k = ((d_blk + 1 > 2) ? d_blk + 1 : 2) + `DISP_ACK_DLY;
            if (k > exp_k) exp_k = k;
        end

        @(posedge clk);
        bus.addr  <= a;
        bus.dout  <= wdata;
        bus.rnw   <= rnw;
        bus.uds_n <= ds_n[1];
        bus.lds_n <= ds_n[0];
        bus.as_n  <= 1'b0;
        rom_ok <= (d_rom == 0);
        ram_ok <= (d_ram == 0);
        lhbl   <= (d_blk != 0);
        k = 0;
        do begin
            @(posedge clk);
            k++;
            rom_ok <= (k >= d_rom);
            ram_ok <= (k >= d_ram);
            lhbl   <= !(k >= d_blk);
            @(negedge clk);
            if (k == 1) check_sel(sel_m, sel);
        end while (dtack_n);

        if (k != exp_k) begin
            $display("dtack_n fell %0d cycles after the address, %0d expected at %0t",
                     k, exp_k, $time);
            err_other++;
        end
        rd_m = read_model(sel_m, port_m);
        if (rnw) check_word("rd_data", rd_m, rd_data);

        if (port_m.prisel && !ds_n[0]) latch_m.prisel = wdata[2:0];
        if (port_m.snd && !ds_n[0]) latch_m.snd_latch = wdata[7:0];
        if (port_m.mcu_wr && !ds_n[1]) latch_m.mcu_din[15:8] = wdata[15:8];
        if (port_m.mcu_wr && !ds_n[0]) latch_m.mcu_din[7:0] = wdata[7:0];
        if (port_m.mixpsel && !ds_n[0]) latch_m.mixpsel = wdata[0];
        if (port_m.snd) snd_exp++;
        if (port_m.obj_copy) obj_exp++;
        if (port_m.vint_clr) vint_m = 1'b0;
        if (port_m.mcu_rd) secirq_m = 1'b0;

        @(posedge clk);
        bus.as_n <= 1'b1;
        rom_ok <= 1'b0;
        ram_ok <= 1'b0;
        lhbl   <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (!dtack_n) begin
            $display("dtack_n still low one cycle after as_n rose at %0t", $time);
            err_other++;
        end
        check_latch(latch_m, latch);
        check_ipl(~ipl_model(vint_m, secirq_m, ext_irq_n), ipl_n);
        if (snd_seen != snd_exp || obj_seen != obj_exp) begin
            $display("strobe pulses wrong at %0t: snd_req %0d of %0d, obj_copy %0d of %0d",
                     $time, snd_seen, snd_exp, obj_seen, obj_exp);
            err_other++;
            snd_exp = snd_seen;     // report each miss once
            obj_exp = obj_seen;
        end
    endtask

    initial begin
        logic [23:1] a;
        logic        rnw;
        logic [1:0]  ds_n;
        logic [15:0] wdata;
        logic [31:0] t;
        logic [63:0] w;
        rst       = 1'b1;
        bus       = '0;
        bus.rnw   = 1'b1;
        bus.uds_n = 1'b1;
        bus.lds_n = 1'b1;
        bus.as_n  = 1'b1;
        cab       = '1;      // nothing pressed
        lvbl      = 1'b1;
        lhbl      = 1'b1;
        ext_irq_n = 1'b1;
        sec2      = 1'b0;
        rom_ok    = 1'b0;
        ram_ok    = 1'b0;
        rom_data  = '0;
        ram_data  = '0;
        pal_dout  = '0;
        obj_dout  = '0;
        ba0_dout  = '0;
        ba1_dout  = '0;
        ba2_dout  = '0;
        mcu_dout  = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < N_ACC; i++) begin
            t = rand_next();
            @(posedge clk);
            w = {rand_next(), rand_next()};
            rom_data <= w[15:0];
            ram_data <= w[31:16];
            pal_dout <= w[47:32];
            obj_dout <= w[63:48];
            w = {rand_next(), rand_next()};
            ba0_dout <= w[15:0];
            ba1_dout <= w[31:16];
            ba2_dout <= w[47:32];
            mcu_dout <= w[63:48];
            if (t[2:0] == 3'd0) begin   // new cabinet state held for a while
                w = {rand_next(), rand_next()};
                cab <= w[$bits(cab_in_t)-1:0];
            end
            if (t[5:3] == 3'd0) ext_irq_n <= !ext_irq_n;
            if (t[7]) frame_pulse();
            if (t[10:8] == 3'd0) sec2_pulse();
            make_addr(a, rnw, ds_n, wdata);
            do_access(a, rnw, ds_n, wdata);
        end

        $display("errors: %0d wrong values, %0d other failures", err_val, err_other);
        if (err_val == 0 && err_other == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
+incdir+sim
hw/main_bus_pkg.sv
hw/addr_decoder.sv
hw/io_registers.sv
hw/cab_inputs.sv
hw/read_mux.sv
hw/wait_gen.sv
hw/main_bus.sv
sim/main_bus_tb.sv

// File: Makefile
TB_TOP  = main_bus_tb
RTL_TOP = main_bus

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f build.f --top-module $(RTL_TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ps -f build.f \
		--top-module $(TB_TOP) -o simv
	@out="$$(./obj_dir/simv)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir
